// File: verilog.f
common/avalon_mem_pkg.sv
common/local_mem_cfg_pkg.sv
common/avalon_mem_if.sv
local_mem/local_mem_burst_mapper.sv
local_mem/local_mem_reg_pipe.sv
logic/local_mem_model.sv
local_mem/local_mem_as_avalon.sv
testbench/local_mem_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := local_mem_tb
FILE_LIST  := verilog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
PASS_TEXT  := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/local_mem_tb.sv
// Directed testbench for the local memory subsystem with a reference memory and result counts
`timescale 1ns/1ps

module local_mem_tb;

    localparam int half_period = 10;
    localparam int reset_cycles = 5;
    localparam int accept_timeout = 200;
    localparam int drain_timeout = 500;
    localparam int depth = local_mem_cfg_pkg::mem_depth_words;
    // Reads only touch this region, which is written in full first
    localparam int filled_words = 128;
    // A stray beat would show up within the memory latency and both pipeline directions
    localparam int settle_cycles = local_mem_cfg_pkg::mem_read_latency
                                   + 2 * local_mem_cfg_pkg::timing_reg_stages + 4;

    logic clk;
    logic reset;
    avalon_mem_pkg::addr_t address;
    avalon_mem_pkg::afu_burst_t burstcount;
    logic read;
    logic write;
    avalon_mem_pkg::data_t writedata;
    avalon_mem_pkg::byteenable_t byteenable;
    logic waitrequest;
    avalon_mem_pkg::data_t readdata;
    logic readdatavalid;

    // Expected memory contents as of the last accepted write beat
    avalon_mem_pkg::data_t ref_mem [depth];
    // Read beats still owed by the DUT in the order they will return
    avalon_mem_pkg::data_t exp_q [$];
    // Data and byte enables of the next write burst by beat number
    avalon_mem_pkg::data_t beat_data [16];
    avalon_mem_pkg::byteenable_t beat_be [16];

    int beats_seen = 0;
    int error_count = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic timeout_hit = 1'b0;
    string timeout_what;

    local_mem_as_avalon uut
    (
        .afu_clk(clk),
        .reset(reset),
        .address(address),
        .burstcount(burstcount),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .readdatavalid(readdatavalid)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #half_period clk = ~clk;
        end
    end

    // ========================================================================
    // Reporting and reference model
    // ========================================================================

    task automatic note_mismatch(input string msg);
        error_count++;
        test_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0)
        begin
            $display("ok    %s", name);
        end
        else
        begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Hands the stuck wait to the watchdog and parks the test sequence
    task automatic report_timeout(input string what);
        timeout_what = what;
        timeout_hit = 1'b1;
        wait (timeout_hit === 1'b0);
    endtask

    // Only lanes with their enable set take the new byte
    function automatic avalon_mem_pkg::data_t merge_bytes(input avalon_mem_pkg::data_t old_word,
                                                          input avalon_mem_pkg::data_t new_word,
                                                          input avalon_mem_pkg::byteenable_t be);
        avalon_mem_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < avalon_mem_pkg::byteenable_width; b++)
        begin
            if (be[b])
            begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Every 16-bit field depends on the whole word address
    function automatic avalon_mem_pkg::data_t fill_word(input avalon_mem_pkg::addr_t addr);
        return {addr ^ 16'h5a5a, ~addr, addr * 16'd3, addr ^ 16'hc0de};
    endfunction

    // Read beats are checked in order as they come back
    initial
    begin
        avalon_mem_pkg::data_t expected;
        forever
        begin
            @(negedge clk);
            if (readdatavalid === 1'b1)
            begin
                beats_seen++;
                assert (exp_q.size() > 0)
                else
                begin
                    error_count++;
                    test_errors++;
                    $display("Extra read beat at %0t with no read outstanding", $time);
                end
                if (exp_q.size() > 0)
                begin
                    expected = exp_q.pop_front();
                    assert (readdata === expected)
                    else note_mismatch($sformatf("read beat %h, expected %h", readdata, expected));
                end
            end
        end
    end

    initial
    begin
        wait (timeout_hit === 1'b1);
        $display("Timeout while waiting for %s at %0t", timeout_what, $time);
        $display("TESTS FAILED");
        $finish;
    end

    // ========================================================================
    // Bus tasks
    // ========================================================================

    // Waitrequest is looked at mid-way through the low clock phase
    task automatic wait_accept(input string what);
        int cycles;
        cycles = 0;
        #(half_period / 2);
        while (waitrequest !== 1'b0 && cycles < accept_timeout)
        begin
            @(negedge clk);
            #(half_period / 2);
            cycles++;
        end
        if (waitrequest !== 1'b0)
        begin
            report_timeout(what);
        end
        // The transfer takes place on this edge
        @(posedge clk);
    endtask

    task automatic drain_responses();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < drain_timeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            report_timeout("read data to return");
        end
        // Beats beyond the expected ones land in the count before it is checked
        repeat (settle_cycles) @(negedge clk);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        read = 1'b0;
        write = 1'b0;
    endtask

    task automatic write_burst(input avalon_mem_pkg::addr_t addr, input int len);
        int idx;
        for (int k = 0; k < len; k++)
        begin
            @(negedge clk);
            write = 1'b1;
            read = 1'b0;
            address = addr;
            burstcount = avalon_mem_pkg::afu_burst_t'(len);
            writedata = beat_data[k];
            byteenable = beat_be[k];
            wait_accept("write beat accept");
            idx = (int'(addr) + k) % depth;
            ref_mem[idx] = merge_bytes(ref_mem[idx], beat_data[k], beat_be[k]);
        end
        bus_idle();
    endtask

    // Early chunks of a long read return before the AFU command is accepted
    task automatic drive_read(input avalon_mem_pkg::addr_t addr, input int len);
        @(negedge clk);
        read = 1'b1;
        write = 1'b0;
        address = addr;
        burstcount = avalon_mem_pkg::afu_burst_t'(len);
        for (int k = 0; k < len; k++)
        begin
            exp_q.push_back(ref_mem[(int'(addr) + k) % depth]);
        end
        wait_accept("read accept");
    endtask

    task automatic read_and_check(input avalon_mem_pkg::addr_t addr, input int len);
        int first_beat;
        first_beat = beats_seen;
        drive_read(addr, len);
        bus_idle();
        drain_responses();
        assert (beats_seen - first_beat == len)
        else note_mismatch($sformatf("read of %0d words at %h gave %0d beats",
                                     len, addr, beats_seen - first_beat));
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic apply_reset();
        for (int c = 0; c < reset_cycles; c++)
        begin
            @(negedge clk);
            assert (waitrequest === 1'b1) else note_mismatch("waitrequest low during reset");
            assert (readdatavalid === 1'b0) else note_mismatch("readdatavalid high during reset");
        end
        reset = 1'b0;
        // The first cycle out of reset still stalls the AFU
        #(half_period / 2);
        assert (waitrequest === 1'b1) else note_mismatch("waitrequest low right after reset");
        assert (readdatavalid === 1'b0) else note_mismatch("readdatavalid high after reset");
        end_test("reset state");
    endtask

    task automatic single_beat_roundtrip();
        beat_data[0] = {$urandom, $urandom};
        beat_be[0] = '1;
        write_burst(16'd10, 1);
        read_and_check(16'd10, 1);
        end_test("single beat write and read");
    endtask

    task automatic byte_enable_merge();
        for (int blk = 0; blk < filled_words / 16; blk++)
        begin
            for (int k = 0; k < 16; k++)
            begin
                beat_data[k] = fill_word(avalon_mem_pkg::addr_t'(16 * blk + k));
                beat_be[k] = '1;
            end
            write_burst(avalon_mem_pkg::addr_t'(16 * blk), 16);
        end
        for (int k = 0; k < 16; k++)
        begin
            beat_data[k] = {$urandom, $urandom};
            beat_be[k] = avalon_mem_pkg::byteenable_t'($urandom);
        end
        beat_be[0] = '0;
        beat_be[1] = '1;
        write_burst(16'd37, 16);
        read_and_check(16'd37, 16);
        end_test("16-beat byte-enable merge");
    endtask

    // Covers no split, an exact split and splits with a remainder
    task automatic burst_length_sweep();
        int lens [6] = '{1, 3, 4, 5, 9, 16};
        for (int k = 0; k < 6; k++)
        begin
            read_and_check(avalon_mem_pkg::addr_t'(11 * k + 5), lens[k]);
        end
        end_test("read burst lengths");
    endtask

    task automatic back_to_back_reads();
        int lens [5] = '{2, 16, 4, 7, 1};
        int first_beat;
        int total;
        first_beat = beats_seen;
        total = 0;
        for (int k = 0; k < 5; k++)
        begin
            drive_read(avalon_mem_pkg::addr_t'(13 * k + 2), lens[k]);
            total += lens[k];
        end
        bus_idle();
        drain_responses();
        assert (beats_seen - first_beat == total)
        else note_mismatch($sformatf("%0d beats for back-to-back reads, expected %0d",
                                     beats_seen - first_beat, total));
        end_test("back-to-back reads");
    endtask

    task automatic random_traffic();
        int first_beat;
        int total;
        int len;
        avalon_mem_pkg::addr_t addr;
        first_beat = beats_seen;
        total = 0;
        for (int n = 0; n < 40; n++)
        begin
            len = int'($urandom_range(16, 1));
            addr = avalon_mem_pkg::addr_t'($urandom_range(filled_words - 16, 0));
            if ($urandom_range(1, 0) == 1)
            begin
                for (int k = 0; k < len; k++)
                begin
                    beat_data[k] = {$urandom, $urandom};
                    beat_be[k] = avalon_mem_pkg::byteenable_t'($urandom);
                end
                write_burst(addr, len);
            end
            else
            begin
                drive_read(addr, len);
                total += len;
            end
        end
        bus_idle();
        drain_responses();
        assert (beats_seen - first_beat == total)
        else note_mismatch($sformatf("%0d beats in random mix, expected %0d",
                                     beats_seen - first_beat, total));
        end_test("random write and read mix");
    endtask

    initial
    begin
        void'($urandom(32'h31550197));
        reset = 1'b1;
        read = 1'b0;
        write = 1'b0;
        address = '0;
        burstcount = '0;
        writedata = '0;
        byteenable = '0;
        apply_reset();
        single_beat_roundtrip();
        byte_enable_merge();
        burst_length_sweep();
        back_to_back_reads();
        random_traffic();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: local_mem/local_mem_as_avalon.sv
// Local memory subsystem top level with burst mapping, timing stages and memory
`timescale 1ns/1ps

module local_mem_as_avalon
(
    input  logic afu_clk,
    input  logic reset,
    input  avalon_mem_pkg::addr_t address,
    input  avalon_mem_pkg::afu_burst_t burstcount,
    input  logic read,
    input  logic write,
    input  avalon_mem_pkg::data_t writedata,
    input  avalon_mem_pkg::byteenable_t byteenable,
    output logic waitrequest,
    output avalon_mem_pkg::data_t readdata,
    output logic readdatavalid
);

    // AFU-facing bus with the long burst count
    avalon_mem_if #(.burst_cnt_width(avalon_mem_pkg::afu_burst_cnt_width)) afu_side_if ();

    // Memory-sized bursts, before and after the timing stages
    avalon_mem_if #(.burst_cnt_width(avalon_mem_pkg::mem_burst_cnt_width)) mapped_if ();
    avalon_mem_if #(.burst_cnt_width(avalon_mem_pkg::mem_burst_cnt_width)) mem_if ();

    // The AFU ports map one to one onto the AFU-side bus
    assign afu_side_if.address = address;
    assign afu_side_if.burstcount = burstcount;
    assign afu_side_if.read = read;
    assign afu_side_if.write = write;
    assign afu_side_if.writedata = writedata;
    assign afu_side_if.byteenable = byteenable;
    assign waitrequest = afu_side_if.waitrequest;
    assign readdata = afu_side_if.readdata;
    assign readdatavalid = afu_side_if.readdatavalid;

    local_mem_burst_mapper map_bursts
    (
        .clk(afu_clk),
        .reset(reset),
        .afu(afu_side_if.slave),
        .mem(mapped_if.master)
    );

    local_mem_reg_pipe
    #(
        .n_stages(local_mem_cfg_pkg::timing_reg_stages)
    )
    mem_pipe
    (
        .clk(afu_clk),
        .reset(reset),
        .up(mapped_if.slave),
        .down(mem_if.master)
    );

    // Stand-in for the memory controller
    local_mem_model mem_model
    (
        .clk(afu_clk),
        .reset(reset),
        .mem(mem_if.slave)
    );

endmodule

// File: logic/local_mem_model.sv
// Behavioral burst memory with byte-enable writes and fixed-latency reads
`timescale 1ns/1ps

module local_mem_model
(
    input logic clk,
    input logic reset,
    avalon_mem_if.slave mem
);

    avalon_mem_pkg::data_t mem_array [local_mem_cfg_pkg::mem_depth_words];

    // Write burst state, index is start address plus beat number
    logic wr_active;
    avalon_mem_pkg::mem_burst_t wr_left;
    local_mem_cfg_pkg::mem_index_t wr_next;

    // Read burst state, one burst in flight at a time
    logic rd_busy;
    local_mem_cfg_pkg::read_delay_t rd_delay;
    avalon_mem_pkg::mem_burst_t rd_left;
    local_mem_cfg_pkg::mem_index_t rd_next;

    logic rd_valid_q;
    avalon_mem_pkg::data_t rd_data_q;

    local_mem_cfg_pkg::mem_index_t wr_index;
    avalon_mem_pkg::mem_burst_t wr_count;
    logic wr_fire;
    logic rd_fire;
    logic rd_issue;

    // ========================================================================
    // Handshake
    // ========================================================================

    // Held high while a read burst counts down and drains
    assign mem.waitrequest = rd_busy;
    assign mem.readdatavalid = rd_valid_q;
    assign mem.readdata = rd_data_q;

    assign wr_fire = mem.write && !rd_busy;
    assign rd_fire = mem.read && !rd_busy;
    assign rd_issue = rd_busy && rd_delay == '0;

    // Only the first write beat carries address and burst count
    assign wr_index = wr_active ? wr_next : local_mem_cfg_pkg::mem_index_t'(mem.address);
    assign wr_count = wr_active ? wr_left : mem.burstcount;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_active <= 1'b0;
            rd_busy <= 1'b0;
            rd_valid_q <= 1'b0;
        end
        else
        begin
            if (wr_fire)
            begin
                wr_active <= wr_count != avalon_mem_pkg::mem_burst_t'(1);
            end
            // The last beat issued reopens the memory for commands
            if (rd_fire)
            begin
                rd_busy <= 1'b1;
            end
            else if (rd_issue && rd_left == avalon_mem_pkg::mem_burst_t'(1))
            begin
                rd_busy <= 1'b0;
            end
            rd_valid_q <= rd_issue;
        end
    end

    // ========================================================================
    // Burst counters and storage
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (wr_fire)
        begin
            wr_next <= wr_index + 1'b1;
            wr_left <= wr_count - 1'b1;
        end
        // Two cycles of the latency are the accept and output registers
        if (rd_fire)
        begin
            rd_delay <= local_mem_cfg_pkg::read_delay_t'(local_mem_cfg_pkg::mem_read_latency - 2);
            rd_left <= mem.burstcount;
            rd_next <= local_mem_cfg_pkg::mem_index_t'(mem.address);
        end
        else if (rd_issue)
        begin
            rd_left <= rd_left - 1'b1;
            rd_next <= rd_next + 1'b1;
            rd_data_q <= mem_array[rd_next];
        end
        else if (rd_busy)
        begin
            rd_delay <= rd_delay - 1'b1;
        end
    end

    // Each byte lane is written only when its enable is set
    always_ff @(posedge clk)
    begin
        if (wr_fire)
        begin
            for (int b = 0; b < avalon_mem_pkg::byteenable_width; b++)
            begin
                if (mem.byteenable[b])
                begin
                    mem_array[wr_index][8*b +: 8] <= mem.writedata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: local_mem/local_mem_reg_pipe.sv
// Waitrequest-honoring command register stages and read response pipeline
`timescale 1ns/1ps

module local_mem_reg_pipe
#(
    parameter int n_stages = local_mem_cfg_pkg::timing_reg_stages
)
(
    input logic clk,
    input logic reset,
    avalon_mem_if.slave up,
    avalon_mem_if.master down
);

    // Low during reset and the first cycle after it, which stalls the AFU
    logic run;

    // Index i is the input of stage i, index n_stages feeds the memory
    logic [n_stages:0] cmd_valid;
    logic [n_stages:0] cmd_stall;
    avalon_mem_pkg::cmd_t cmd_data [n_stages+1];

    // Read responses, index 0 from the memory side
    logic [n_stages:0] rsp_valid;
    avalon_mem_pkg::data_t rsp_data [n_stages+1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run <= 1'b0;
        end
        else
        begin
            run <= 1'b1;
        end
    end

    assign cmd_valid[0] = up.read || up.write;
    assign cmd_data[0] = {up.address, up.burstcount, up.read, up.write,
                          up.writedata, up.byteenable};
    assign up.waitrequest = cmd_stall[0];
    assign cmd_stall[n_stages] = down.waitrequest;

    // The last stage presents its command until the memory takes it
    assign down.address = cmd_data[n_stages].address;
    assign down.burstcount = cmd_data[n_stages].burstcount;
    assign down.read = cmd_valid[n_stages] && cmd_data[n_stages].read;
    assign down.write = cmd_valid[n_stages] && cmd_data[n_stages].write;
    assign down.writedata = cmd_data[n_stages].writedata;
    assign down.byteenable = cmd_data[n_stages].byteenable;

    assign rsp_valid[0] = down.readdatavalid;
    assign rsp_data[0] = down.readdata;
    assign up.readdatavalid = rsp_valid[n_stages];
    assign up.readdata = rsp_data[n_stages];

    for (genvar i = 0; i < n_stages; i++)
    begin : stage
        logic main_valid;
        logic skid_valid;
        avalon_mem_pkg::cmd_t main_data;
        avalon_mem_pkg::cmd_t skid_data;
        logic take_in;
        logic move_out;

        // Stall upstream comes from a flop, so the skid slot catches
        // the one command that arrives while it propagates
        assign cmd_stall[i] = skid_valid || !run;
        assign take_in = cmd_valid[i] && !cmd_stall[i];
        assign move_out = !main_valid || !cmd_stall[i+1];
        assign cmd_valid[i+1] = main_valid;
        assign cmd_data[i+1] = main_data;

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
            end
            else if (move_out)
            begin
                // Drain the skid slot first to keep commands in order
                main_valid <= skid_valid || take_in;
                skid_valid <= 1'b0;
            end
            else if (take_in)
            begin
                skid_valid <= 1'b1;
            end
        end

        always_ff @(posedge clk)
        begin
            if (move_out)
            begin
                main_data <= skid_valid ? skid_data : cmd_data[i];
            end
            else if (take_in)
            begin
                skid_data <= cmd_data[i];
            end
        end

        // Read responses have no back-pressure, so plain registers do
        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                rsp_valid[i+1] <= 1'b0;
            end
            else
            begin
                rsp_valid[i+1] <= rsp_valid[i];
            end
        end

        always_ff @(posedge clk)
        begin
            rsp_data[i+1] <= rsp_data[i];
        end
    end

endmodule

// File: local_mem/local_mem_burst_mapper.sv
// Burst mapper that splits long AFU bursts into memory-sized bursts
`timescale 1ns/1ps

module local_mem_burst_mapper
(
    input logic clk,
    input logic reset,
    avalon_mem_if.slave afu,
    avalon_mem_if.master mem
);

    // Set while an AFU burst is only partly sent to the memory side
    logic active;
    // Beats left in the AFU burst and the address of the next chunk
    avalon_mem_pkg::afu_burst_t left;
    avalon_mem_pkg::addr_t next_addr;
    // Write beats still owed to the current memory chunk
    avalon_mem_pkg::mem_burst_t chunk_left;

    avalon_mem_pkg::afu_burst_t cmd_left;
    avalon_mem_pkg::addr_t cmd_addr;
    avalon_mem_pkg::mem_burst_t chunk_len;
    logic long_cmd;
    logic new_chunk;
    logic wr_fire;
    logic rd_fire;

    // ========================================================================
    // Command view of the current chunk
    // ========================================================================

    always_comb
    begin
        // The first chunk comes straight from the AFU, later ones from state
        cmd_left = active ? left : afu.burstcount;
        cmd_addr = active ? next_addr : afu.address;
        long_cmd = cmd_left > avalon_mem_pkg::afu_burst_t'(avalon_mem_pkg::mem_max_burst);
        chunk_len = long_cmd ? avalon_mem_pkg::mem_max_burst
                             : avalon_mem_pkg::mem_burst_t'(cmd_left);
        // A write beat opens a new memory burst once the last chunk is full
        new_chunk = chunk_left == '0;
    end

    assign wr_fire = afu.write && !mem.waitrequest;
    assign rd_fire = afu.read && !mem.waitrequest;

    // The data path is combinational, so mapping adds no cycle
    assign mem.address = cmd_addr;
    assign mem.burstcount = chunk_len;
    assign mem.read = afu.read;
    assign mem.write = afu.write;
    assign mem.writedata = afu.writedata;
    assign mem.byteenable = afu.byteenable;

    // A long read is held at the AFU until its final chunk goes out
    assign afu.waitrequest = mem.waitrequest || (afu.read && long_cmd);

    // Responses stay in order, so read data needs no reassembly
    assign afu.readdata = mem.readdata;
    assign afu.readdatavalid = mem.readdatavalid;

    // ========================================================================
    // Burst tracking
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            chunk_left <= '0;
        end
        else if (wr_fire)
        begin
            // The burst stays open until its last beat is sent
            active <= cmd_left != avalon_mem_pkg::afu_burst_t'(1);
            if (new_chunk)
            begin
                chunk_left <= chunk_len - 1'b1;
            end
            else
            begin
                chunk_left <= chunk_left - 1'b1;
            end
        end
        else if (rd_fire)
        begin
            active <= long_cmd;
        end
    end

    // Beat counts and addresses are only read while active is set
    always_ff @(posedge clk)
    begin
        if (wr_fire)
        begin
            left <= cmd_left - 1'b1;
            if (new_chunk)
            begin
                next_addr <= cmd_addr + avalon_mem_pkg::addr_t'(chunk_len);
            end
        end
        else if (rd_fire)
        begin
            left <= cmd_left - avalon_mem_pkg::afu_burst_t'(chunk_len);
            next_addr <= cmd_addr + avalon_mem_pkg::addr_t'(chunk_len);
        end
    end

endmodule

// File: common/avalon_mem_if.sv
// Avalon memory-mapped interface with master and slave modports
`timescale 1ns/1ps

interface avalon_mem_if
#(
    parameter int burst_cnt_width = avalon_mem_pkg::mem_burst_cnt_width
);

    // Command and write data, driven by the master
    avalon_mem_pkg::addr_t address;
    logic [burst_cnt_width-1:0] burstcount;
    logic read;
    logic write;
    avalon_mem_pkg::data_t writedata;
    avalon_mem_pkg::byteenable_t byteenable;

    // Flow control and read responses, driven by the slave
    logic waitrequest;
    avalon_mem_pkg::data_t readdata;
    logic readdatavalid;

    modport master
    (
        output address,
        output burstcount,
        output read,
        output write,
        output writedata,
        output byteenable,
        input  waitrequest,
        input  readdata,
        input  readdatavalid
    );

    modport slave
    (
        input  address,
        input  burstcount,
        input  read,
        input  write,
        input  writedata,
        input  byteenable,
        output waitrequest,
        output readdata,
        output readdatavalid
    );

endinterface

// File: common/local_mem_cfg_pkg.sv
// Subsystem configuration for timing stages, memory depth and read latency
package local_mem_cfg_pkg;

    // Command register stages between the burst mapper and the memory
    localparam int timing_reg_stages = 2;

    // Size of the behavioral memory, a power of two so the index wraps
    localparam int mem_depth_words = 1024;
    localparam int mem_index_bits = $clog2(mem_depth_words);

    // Cycles from read acceptance to the first read beat, at least 2
    localparam int mem_read_latency = 3;
    localparam int read_delay_bits = $clog2(mem_read_latency);

    typedef logic [mem_index_bits-1:0] mem_index_t;
    typedef logic [read_delay_bits-1:0] read_delay_t;

endpackage

// File: common/avalon_mem_pkg.sv
// Avalon memory bus widths, derived sizes, bus types and the packed command
package avalon_mem_pkg;

    // Word address and data beat sizes shared by the AFU and memory sides
    localparam int addr_width = 16;
    localparam int data_width = 64;
    localparam int byteenable_width = data_width / 8;

    // The AFU may ask for bursts of up to 16 beats, so its count needs 5 bits
    localparam int afu_burst_cnt_width = 5;

    // The memory side only takes bursts of up to 4 beats
    localparam int mem_burst_cnt_width = 3;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [byteenable_width-1:0] byteenable_t;
    typedef logic [afu_burst_cnt_width-1:0] afu_burst_t;
    typedef logic [mem_burst_cnt_width-1:0] mem_burst_t;

    // Largest memory burst, already sized to the memory burst count
    localparam mem_burst_t mem_max_burst = mem_burst_t'(4);

    // One memory-side command or write beat as it moves through the
    // timing register stages
    typedef struct packed {
        addr_t       address;
        mem_burst_t  burstcount;
        logic        read;
        logic        write;
        data_t       writedata;
        byteenable_t byteenable;
    } cmd_t;

endpackage
